// File: include/rv_settings.svh
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// data path width
`define RV_XLEN 32

// integer register file, x0 included
`define RV_REG_COUNT 32

// unified memory depth in words
`define RV_MEM_WORDS 1024

// fetching from here ends the run
`define RV_EXIT_PC 32'h0000_0ffc

`endif

// File: logic/rv_isa_pkg.sv
package rv_isa_pkg;

	// major opcodes
	localparam logic [6:0] OPC_LOAD   = 7'b000_0011;
	localparam logic [6:0] OPC_STORE  = 7'b010_0011;
	localparam logic [6:0] OPC_OP     = 7'b011_0011;
	localparam logic [6:0] OPC_OP_IMM = 7'b001_0011;
	localparam logic [6:0] OPC_BRANCH = 7'b110_0011;
	localparam logic [6:0] OPC_JAL    = 7'b110_1111;
	localparam logic [6:0] OPC_JALR   = 7'b110_0111;
	localparam logic [6:0] OPC_LUI    = 7'b011_0111;
	localparam logic [6:0] OPC_AUIPC  = 7'b001_0111;
	localparam logic [6:0] OPC_SYSTEM = 7'b111_0011;

	localparam logic [2:0] F3_LW   = 3'b010;
	localparam logic [2:0] F3_SW   = 3'b010;
	localparam logic [2:0] F3_JALR = 3'b000;

	// register and immediate arithmetic
	localparam logic [2:0] F3_ADD  = 3'b000;
	localparam logic [2:0] F3_SLL  = 3'b001;
	localparam logic [2:0] F3_SLT  = 3'b010;
	localparam logic [2:0] F3_SLTU = 3'b011;
	localparam logic [2:0] F3_XOR  = 3'b100;
	localparam logic [2:0] F3_SR   = 3'b101; // srl or sra, by funct7
	localparam logic [2:0] F3_OR   = 3'b110;
	localparam logic [2:0] F3_AND  = 3'b111;

	localparam logic [2:0] F3_BEQ  = 3'b000;
	localparam logic [2:0] F3_BNE  = 3'b001;
	localparam logic [2:0] F3_BLT  = 3'b100;
	localparam logic [2:0] F3_BGE  = 3'b101;
	localparam logic [2:0] F3_BLTU = 3'b110;
	localparam logic [2:0] F3_BGEU = 3'b111;

	localparam logic [2:0] F3_CSRRW  = 3'b001;
	localparam logic [2:0] F3_CSRRS  = 3'b010;
	localparam logic [2:0] F3_CSRRC  = 3'b011;
	localparam logic [2:0] F3_CSRRWI = 3'b101;
	localparam logic [2:0] F3_CSRRSI = 3'b110;
	localparam logic [2:0] F3_CSRRCI = 3'b111;

	localparam logic [6:0] F7_BASE = 7'b000_0000;
	localparam logic [6:0] F7_ALT  = 7'b010_0000; // sub, sra, srai

	localparam logic [31:0] INST_ECALL = 32'h0000_0073;

	localparam logic [11:0] CSR_MTVEC    = 12'h305;
	localparam logic [11:0] CSR_MSCRATCH = 12'h340;
	localparam logic [11:0] CSR_MEPC     = 12'h341;
	localparam logic [11:0] CSR_MCAUSE   = 12'h342;

	localparam logic [31:0] CAUSE_ECALL_M = 32'd11;

endpackage

// File: logic/rv_ctrl_pkg.sv
package rv_ctrl_pkg;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
		ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU,
		ALU_JALR, // add then clear bit 0
		ALU_COPY1,
		ALU_NONE
	} alu_op_e;

	typedef enum logic [2:0] {
		BR_NONE, BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU
	} br_op_e;

	// imz is the 5 bit csr immediate, zero extended
	typedef enum logic [1:0] {OP1_RS1, OP1_PC, OP1_IMZ, OP1_ZERO} op1_sel_e;

	typedef enum logic [2:0] {
		OP2_RS2, OP2_IMI, OP2_IMS, OP2_IMJ, OP2_IMU, OP2_ZERO
	} op2_sel_e;

	typedef enum logic [2:0] {WB_ALU, WB_MEM, WB_PC4, WB_CSR, WB_NONE} wb_sel_e;

	typedef enum logic [2:0] {
		CSR_NONE, CSR_WRITE, CSR_SET, CSR_CLEAR, CSR_ECALL
	} csr_cmd_e;

endpackage

// File: logic/rv_decoder.sv
`timescale 1ns/1ps
`include "rv_settings.svh"

module rv_decoder (
	input  logic [`RV_XLEN-1:0]              instr_i,
	output rv_ctrl_pkg::alu_op_e             alu_op_o,
	output rv_ctrl_pkg::br_op_e              br_op_o,
	output rv_ctrl_pkg::op1_sel_e            op1_sel_o,
	output rv_ctrl_pkg::op2_sel_e            op2_sel_o,
	output rv_ctrl_pkg::wb_sel_e             wb_sel_o,
	output rv_ctrl_pkg::csr_cmd_e            csr_cmd_o,
	output logic                             mem_wen_o,
	output logic                             rf_wen_o,
	output logic                             jump_o,
	output logic [$clog2(`RV_REG_COUNT)-1:0] rs1_addr_o,
	output logic [$clog2(`RV_REG_COUNT)-1:0] rs2_addr_o,
	output logic [$clog2(`RV_REG_COUNT)-1:0] rd_addr_o,
	output logic [`RV_XLEN-1:0]              imm_i_o,
	output logic [`RV_XLEN-1:0]              imm_s_o,
	output logic [`RV_XLEN-1:0]              imm_b_o,
	output logic [`RV_XLEN-1:0]              imm_j_o,
	output logic [`RV_XLEN-1:0]              imm_u_o,
	output logic [`RV_XLEN-1:0]              imm_z_o
);
	import rv_isa_pkg::*;
	import rv_ctrl_pkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic       alt;
	logic       op_legal;
	logic       imm_legal;

	function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt_form);
		case (f3)
			F3_ADD:  return alt_form ? ALU_SUB : ALU_ADD;
			F3_SLL:  return ALU_SLL;
			F3_SLT:  return ALU_SLT;
			F3_SLTU: return ALU_SLTU;
			F3_XOR:  return ALU_XOR;
			F3_SR:   return alt_form ? ALU_SRA : ALU_SRL;
			F3_OR:   return ALU_OR;
			default: return ALU_AND;
		endcase
	endfunction

	assign opcode = instr_i[6:0];
	assign funct3 = instr_i[14:12];
	assign funct7 = instr_i[31:25];
	assign alt    = (funct7 == F7_ALT);

	assign rs1_addr_o = instr_i[19:15];
	assign rs2_addr_o = instr_i[24:20];
	assign rd_addr_o  = instr_i[11:7];

	assign imm_i_o = {{(`RV_XLEN-12){instr_i[31]}}, instr_i[31:20]};
	assign imm_s_o = {{(`RV_XLEN-12){instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
	assign imm_b_o = {{(`RV_XLEN-13){instr_i[31]}}, instr_i[31], instr_i[7],
		instr_i[30:25], instr_i[11:8], 1'b0};
	assign imm_j_o = {{(`RV_XLEN-21){instr_i[31]}}, instr_i[31], instr_i[19:12],
		instr_i[20], instr_i[30:21], 1'b0};
	assign imm_u_o = {instr_i[31:12], 12'h000};
	assign imm_z_o = {{(`RV_XLEN-5){1'b0}}, instr_i[19:15]};

	// only add/sub and srl/sra have an alternate funct7
	assign op_legal  = (funct7 == F7_BASE) || (alt && (funct3 == F3_ADD || funct3 == F3_SR));
	assign imm_legal = (funct3 == F3_SLL) ? (funct7 == F7_BASE) :
		(funct3 == F3_SR) ? (funct7 == F7_BASE || alt) : 1'b1;

	always_comb begin
		alu_op_o  = ALU_NONE;
		br_op_o   = BR_NONE;
		op1_sel_o = OP1_ZERO;
		op2_sel_o = OP2_ZERO;
		wb_sel_o  = WB_NONE;
		csr_cmd_o = CSR_NONE;
		mem_wen_o = 1'b0;
		rf_wen_o  = 1'b0;
		jump_o    = 1'b0;
		case (opcode)
			OPC_LOAD: if (funct3 == F3_LW) begin
				alu_op_o  = ALU_ADD;
				op1_sel_o = OP1_RS1;
				op2_sel_o = OP2_IMI;
				wb_sel_o  = WB_MEM;
				rf_wen_o  = 1'b1;
			end
			OPC_STORE: if (funct3 == F3_SW) begin
				alu_op_o  = ALU_ADD;
				op1_sel_o = OP1_RS1;
				op2_sel_o = OP2_IMS;
				mem_wen_o = 1'b1;
			end
			OPC_OP: if (op_legal) begin
				alu_op_o  = arith_op(funct3, alt);
				op1_sel_o = OP1_RS1;
				op2_sel_o = OP2_RS2;
				wb_sel_o  = WB_ALU;
				rf_wen_o  = 1'b1;
			end
			OPC_OP_IMM: if (imm_legal) begin
				alu_op_o  = arith_op(funct3, alt && funct3 == F3_SR); // addi has no sub form
				op1_sel_o = OP1_RS1;
				op2_sel_o = OP2_IMI;
				wb_sel_o  = WB_ALU;
				rf_wen_o  = 1'b1;
			end
			OPC_BRANCH: begin
				op1_sel_o = OP1_RS1;
				op2_sel_o = OP2_RS2;
				case (funct3)
					F3_BEQ:  br_op_o = BR_BEQ;
					F3_BNE:  br_op_o = BR_BNE;
					F3_BLT:  br_op_o = BR_BLT;
					F3_BGE:  br_op_o = BR_BGE;
					F3_BLTU: br_op_o = BR_BLTU;
					F3_BGEU: br_op_o = BR_BGEU;
					default: br_op_o = BR_NONE;
				endcase
			end
			OPC_JAL: begin
				alu_op_o  = ALU_ADD;
				op1_sel_o = OP1_PC;
				op2_sel_o = OP2_IMJ;
				wb_sel_o  = WB_PC4;
				rf_wen_o  = 1'b1;
				jump_o    = 1'b1;
			end
			OPC_JALR: if (funct3 == F3_JALR) begin
				alu_op_o  = ALU_JALR;
				op1_sel_o = OP1_RS1;
				op2_sel_o = OP2_IMI;
				wb_sel_o  = WB_PC4;
				rf_wen_o  = 1'b1;
				jump_o    = 1'b1;
			end
			OPC_LUI, OPC_AUIPC: begin
				alu_op_o  = ALU_ADD;
				op1_sel_o = (opcode == OPC_AUIPC) ? OP1_PC : OP1_ZERO;
				op2_sel_o = OP2_IMU;
				wb_sel_o  = WB_ALU;
				rf_wen_o  = 1'b1;
			end
			OPC_SYSTEM: begin
				case (funct3)
					F3_CSRRW, F3_CSRRWI: csr_cmd_o = CSR_WRITE;
					F3_CSRRS, F3_CSRRSI: csr_cmd_o = CSR_SET;
					F3_CSRRC, F3_CSRRCI: csr_cmd_o = CSR_CLEAR;
					default: csr_cmd_o = (instr_i == INST_ECALL) ? CSR_ECALL : CSR_NONE;
				endcase
				if (csr_cmd_o inside {CSR_WRITE, CSR_SET, CSR_CLEAR}) begin
					alu_op_o  = ALU_COPY1;
					op1_sel_o = funct3[2] ? OP1_IMZ : OP1_RS1; // immediate forms
					wb_sel_o  = WB_CSR;
					rf_wen_o  = 1'b1;
				end
			end
			default: ;
		endcase
	end

	always_comb begin
		assert (!(mem_wen_o && rf_wen_o))
			else $error("store decoded with register write, instr %h", instr_i);
	end

endmodule

// File: logic/rv_exec_unit.sv
`timescale 1ns/1ps
`include "rv_settings.svh"

module rv_exec_unit (
	input  rv_ctrl_pkg::alu_op_e  alu_op_i,
	input  rv_ctrl_pkg::br_op_e   br_op_i,
	input  logic [`RV_XLEN-1:0]   op1_i,
	input  logic [`RV_XLEN-1:0]   op2_i,
	output logic [`RV_XLEN-1:0]   alu_result_o,
	output logic                  branch_taken_o
);
	import rv_ctrl_pkg::*;

	logic [4:0] shamt;
	logic       eq;
	logic       lt_s;
	logic       lt_u;

	assign shamt = op2_i[4:0];
	assign eq    = (op1_i == op2_i);
	assign lt_s  = ($signed(op1_i) < $signed(op2_i));
	assign lt_u  = (op1_i < op2_i);

	always_comb begin
		case (alu_op_i)
			ALU_ADD:   alu_result_o = op1_i + op2_i;
			ALU_SUB:   alu_result_o = op1_i - op2_i;
			ALU_AND:   alu_result_o = op1_i & op2_i;
			ALU_OR:    alu_result_o = op1_i | op2_i;
			ALU_XOR:   alu_result_o = op1_i ^ op2_i;
			ALU_SLL:   alu_result_o = op1_i << shamt;
			ALU_SRL:   alu_result_o = op1_i >> shamt;
			ALU_SRA:   alu_result_o = $signed(op1_i) >>> shamt;
			ALU_SLT:   alu_result_o = {{(`RV_XLEN-1){1'b0}}, lt_s};
			ALU_SLTU:  alu_result_o = {{(`RV_XLEN-1){1'b0}}, lt_u};
			ALU_JALR:  alu_result_o = (op1_i + op2_i) & ~`RV_XLEN'(1);
			ALU_COPY1: alu_result_o = op1_i;
			default:   alu_result_o = '0;
		endcase
	end

	// bge is the complement of blt, equal operands included
	always_comb begin
		case (br_op_i)
			BR_BEQ:  branch_taken_o = eq;
			BR_BNE:  branch_taken_o = !eq;
			BR_BLT:  branch_taken_o = lt_s;
			BR_BGE:  branch_taken_o = !lt_s;
			BR_BLTU: branch_taken_o = lt_u;
			BR_BGEU: branch_taken_o = !lt_u;
			default: branch_taken_o = 1'b0;
		endcase
	end

endmodule

// File: logic/rv_csr_file.sv
`timescale 1ns/1ps
`include "rv_settings.svh"

module rv_csr_file (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [11:0]           addr_i,
	input  rv_ctrl_pkg::csr_cmd_e cmd_i,
	input  logic [`RV_XLEN-1:0]   wdata_i,
	input  logic                  wen_i,
	output logic [`RV_XLEN-1:0]   rdata_o,
	output logic [`RV_XLEN-1:0]   trap_vector_o
);
	import rv_isa_pkg::*;
	import rv_ctrl_pkg::*;

	logic [`RV_XLEN-1:0] mtvec;
	logic [`RV_XLEN-1:0] mcause;
	logic [`RV_XLEN-1:0] mscratch;
	logic [`RV_XLEN-1:0] mepc;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			mtvec    <= '0;
			mcause   <= '0;
			mscratch <= '0;
			mepc     <= '0;
		end else if (wen_i && cmd_i != CSR_NONE) begin
			// ecall arrives addressed to mcause with the cause code as data
			case (addr_i)
				CSR_MTVEC:    mtvec    <= wdata_i;
				CSR_MCAUSE:   mcause   <= wdata_i;
				CSR_MSCRATCH: mscratch <= wdata_i;
				CSR_MEPC:     mepc     <= wdata_i;
				default: ;
			endcase
		end
	end

	always_comb begin
		case (addr_i)
			CSR_MTVEC:    rdata_o = mtvec;
			CSR_MCAUSE:   rdata_o = mcause;
			CSR_MSCRATCH: rdata_o = mscratch;
			CSR_MEPC:     rdata_o = mepc;
			default:      rdata_o = '0; // unimplemented reads as zero
		endcase
	end

	assign trap_vector_o = mtvec;

	// the core's csr phase is one cycle, always followed by execute
	wen_single_pulse: assert property (@(posedge clk) disable iff (!rst_n) wen_i |=> !wen_i)
		else $error("csr write enable held for two cycles");

endmodule

// File: logic/rv_core.sv
`timescale 1ns/1ps
`include "rv_settings.svh"

module rv_core (
	input  logic                clk,
	input  logic                rst_n,
	output logic [`RV_XLEN-1:0] imem_addr_o,
	input  logic [`RV_XLEN-1:0] imem_rdata_i,
	output logic [`RV_XLEN-1:0] dmem_addr_o,
	output logic                dmem_wen_o,
	output logic [`RV_XLEN-1:0] dmem_wdata_o,
	input  logic [`RV_XLEN-1:0] dmem_rdata_i,
	output logic                exit_o,
	output logic [`RV_XLEN-1:0] gp_o
);
	import rv_isa_pkg::*;
	import rv_ctrl_pkg::*;

	localparam int REG_AW = $clog2(`RV_REG_COUNT);

	// settle, optional csr write, execute
	typedef enum logic [1:0] {PH_SETTLE, PH_CSR, PH_EXEC} phase_e;

	phase_e              phase;
	logic [`RV_XLEN-1:0] regs [`RV_REG_COUNT];
	logic [`RV_XLEN-1:0] pc, pc_plus4, next_pc;

	alu_op_e             alu_op;
	br_op_e              br_op;
	op1_sel_e            op1_sel;
	op2_sel_e            op2_sel;
	wb_sel_e             wb_sel;
	csr_cmd_e            csr_cmd;
	logic                mem_wen, rf_wen, jump;
	logic [REG_AW-1:0]   rs1_addr, rs2_addr, rd_addr;
	logic [`RV_XLEN-1:0] imm_i, imm_s, imm_b, imm_j, imm_u, imm_z;

	logic [`RV_XLEN-1:0] rs1_data, rs2_data, op1, op2;
	logic [`RV_XLEN-1:0] alu_result, wb_data;
	logic                branch_taken;
	logic [11:0]         csr_addr;
	logic                csr_wen;
	logic [`RV_XLEN-1:0] csr_wdata, csr_rdata, csr_old, trap_vector;

	rv_decoder rv_decoder_i (
		.instr_i(imem_rdata_i), .alu_op_o(alu_op), .br_op_o(br_op),
		.op1_sel_o(op1_sel), .op2_sel_o(op2_sel), .wb_sel_o(wb_sel), .csr_cmd_o(csr_cmd),
		.mem_wen_o(mem_wen), .rf_wen_o(rf_wen), .jump_o(jump),
		.rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr), .rd_addr_o(rd_addr),
		.imm_i_o(imm_i), .imm_s_o(imm_s), .imm_b_o(imm_b),
		.imm_j_o(imm_j), .imm_u_o(imm_u), .imm_z_o(imm_z)
	);

	rv_exec_unit rv_exec_unit_i (
		.alu_op_i(alu_op), .br_op_i(br_op), .op1_i(op1), .op2_i(op2),
		.alu_result_o(alu_result), .branch_taken_o(branch_taken)
	);

	rv_csr_file rv_csr_file_i (
		.clk(clk), .rst_n(rst_n), .addr_i(csr_addr), .cmd_i(csr_cmd),
		.wdata_i(csr_wdata), .wen_i(csr_wen),
		.rdata_o(csr_rdata), .trap_vector_o(trap_vector)
	);

	assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr]; // x0 reads zero
	assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];
	assign gp_o     = regs[3];

	always_comb begin
		case (op1_sel)
			OP1_RS1: op1 = rs1_data;
			OP1_PC:  op1 = pc;
			OP1_IMZ: op1 = imm_z;
			default: op1 = '0;
		endcase
		case (op2_sel)
			OP2_RS2: op2 = rs2_data;
			OP2_IMI: op2 = imm_i;
			OP2_IMS: op2 = imm_s;
			OP2_IMJ: op2 = imm_j;
			OP2_IMU: op2 = imm_u;
			default: op2 = '0;
		endcase
	end

	assign csr_addr = (csr_cmd == CSR_ECALL) ? CSR_MCAUSE : imm_i[11:0];
	assign csr_wen  = (phase == PH_CSR);

	always_comb begin
		case (csr_cmd)
			CSR_WRITE: csr_wdata = op1;
			CSR_SET:   csr_wdata = csr_rdata | op1;
			CSR_CLEAR: csr_wdata = csr_rdata & ~op1;
			CSR_ECALL: csr_wdata = CAUSE_ECALL_M;
			default:   csr_wdata = '0;
		endcase
		case (wb_sel)
			WB_MEM:  wb_data = dmem_rdata_i;
			WB_PC4:  wb_data = pc_plus4;
			WB_CSR:  wb_data = csr_old; // value before the csr phase write
			default: wb_data = alu_result;
		endcase
	end

	assign pc_plus4 = pc + `RV_XLEN'(4);
	assign next_pc  = branch_taken ? pc + imm_b :
		jump ? alu_result :
		(csr_cmd == CSR_ECALL) ? trap_vector : pc_plus4;

	assign imem_addr_o  = pc;
	assign dmem_addr_o  = alu_result;
	assign dmem_wdata_o = rs2_data;
	assign dmem_wen_o   = mem_wen && (phase == PH_EXEC);
	assign exit_o       = (pc == `RV_EXIT_PC);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			phase <= PH_SETTLE;
			pc    <= '0;
			for (int i = 0; i < `RV_REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else begin
			case (phase)
				PH_SETTLE: if (!exit_o) begin // parked at exit
					phase <= (csr_cmd != CSR_NONE) ? PH_CSR : PH_EXEC;
				end
				PH_CSR: phase <= PH_EXEC;
				default: begin
					phase <= PH_SETTLE;
					pc    <= next_pc;
					if (rf_wen) begin
						regs[rd_addr] <= wb_data;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (csr_wen) begin
			csr_old <= csr_rdata;
		end
	end

	pc_word_aligned: assert property (@(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00)
		else $error("pc misaligned %h", pc);

endmodule

// File: logic/rv_memory.sv
`timescale 1ns/1ps
`include "rv_settings.svh"

module rv_memory (
	input  logic                clk,
	input  logic [`RV_XLEN-1:0] imem_addr_i,
	output logic [`RV_XLEN-1:0] imem_rdata_o,
	input  logic [`RV_XLEN-1:0] dmem_addr_i,
	input  logic                dmem_wen_i,
	input  logic [`RV_XLEN-1:0] dmem_wdata_i,
	output logic [`RV_XLEN-1:0] dmem_rdata_o,
	input  logic                load_we_i,
	input  logic [`RV_XLEN-1:0] load_addr_i,
	input  logic [`RV_XLEN-1:0] load_data_i
);
	localparam int IDX_W = $clog2(`RV_MEM_WORDS);

	logic [`RV_XLEN-1:0] mem [`RV_MEM_WORDS];

	// byte address to word index, upper bits wrap
	function automatic logic [IDX_W-1:0] word_idx(input logic [`RV_XLEN-1:0] addr);
		return addr[IDX_W+1:2];
	endfunction

	assign imem_rdata_o = mem[word_idx(imem_addr_i)];
	assign dmem_rdata_o = mem[word_idx(dmem_addr_i)];

	always_ff @(posedge clk) begin
		if (load_we_i) begin // program load, core held in reset
			mem[word_idx(load_addr_i)] <= load_data_i;
		end else if (dmem_wen_i) begin
			mem[word_idx(dmem_addr_i)] <= dmem_wdata_i;
		end
	end

endmodule

// File: logic/rv_system.sv
`timescale 1ns/1ps
`include "rv_settings.svh"

module rv_system (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                load_we_i,
	input  logic [`RV_XLEN-1:0] load_addr_i,
	input  logic [`RV_XLEN-1:0] load_data_i,
	output logic                exit_o,
	output logic [`RV_XLEN-1:0] gp_o,
	output logic                store_o,
	output logic [`RV_XLEN-1:0] store_addr_o,
	output logic [`RV_XLEN-1:0] store_data_o
);
	logic [`RV_XLEN-1:0] imem_addr;
	logic [`RV_XLEN-1:0] imem_rdata;
	logic [`RV_XLEN-1:0] dmem_rdata;

	// the data write port doubles as the store bus
	rv_core rv_core_i (
		.clk(clk), .rst_n(rst_n),
		.imem_addr_o(imem_addr), .imem_rdata_i(imem_rdata),
		.dmem_addr_o(store_addr_o), .dmem_wen_o(store_o),
		.dmem_wdata_o(store_data_o), .dmem_rdata_i(dmem_rdata),
		.exit_o(exit_o), .gp_o(gp_o)
	);

	rv_memory rv_memory_i (
		.clk(clk),
		.imem_addr_i(imem_addr), .imem_rdata_o(imem_rdata),
		.dmem_addr_i(store_addr_o), .dmem_wen_i(store_o),
		.dmem_wdata_i(store_data_o), .dmem_rdata_o(dmem_rdata),
		.load_we_i(load_we_i), .load_addr_i(load_addr_i), .load_data_i(load_data_i)
	);

endmodule

// File: tests/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
	output logic clk_o
);
	initial begin
		clk_o = 1'b0;
	end

	always #2 clk_o = ~clk_o; // 4 ns period

endmodule

// File: tests/tb_top.sv
`timescale 1ns/1ps
`include "rv_settings.svh"

module tb_top;
	import rv_isa_pkg::*;

	logic        clk;
	logic        rst_n;
	logic        load_we;
	logic [31:0] load_addr;
	logic [31:0] load_data;
	logic        exit;
	logic [31:0] gp;
	logic        store;
	logic [31:0] store_addr;
	logic [31:0] store_data;

	logic [31:0] prog [`RV_MEM_WORDS];
	int          pos;
	int          slot;
	logic [31:0] rng;
	logic [31:0] exp_addr [$];
	logic [31:0] exp_data [$];
	logic [31:0] exp_gp;
	int          ref_steps;
	string       test_name;
	int          watch_limit;
	int          run_cycles;
	bit          running;

	tb_clock tb_clock_i (.clk_o(clk));

	rv_system rv_system_i (
		.clk(clk), .rst_n(rst_n),
		.load_we_i(load_we), .load_addr_i(load_addr), .load_data_i(load_data),
		.exit_o(exit), .gp_o(gp),
		.store_o(store), .store_addr_o(store_addr), .store_data_o(store_data)
	);

	function automatic logic [31:0] next_rand();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
		logic [2:0] f3, logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, OPC_OP};
	endfunction

	function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
		logic [4:0] rd, logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, F3_SW, imm[4:0], OPC_STORE};
	endfunction

	function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
		logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
	endfunction

	function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
	endfunction

	function automatic logic [31:0] enc_u(logic [19:0] imm, logic [4:0] rd, logic [6:0] opc);
		return {imm, rd, opc};
	endfunction

	function automatic void emit(logic [31:0] word);
		prog[pos] = word;
		pos++;
	endfunction

	// lui plus addi with the upper part rounded for the signed low part
	function automatic void load_imm(logic [4:0] rd, logic [31:0] v);
		logic [31:0] upper;
		upper = (v + 32'h800) >> 12;
		emit(enc_u(upper[19:0], rd, OPC_LUI));
		emit(enc_i(v[11:0], rd, F3_ADD, rd, OPC_OP_IMM));
	endfunction

	function automatic void store_out(logic [4:0] rs2);
		logic [31:0] off;
		off = slot * 4;
		emit(enc_s(off[11:0], rs2, 5'd4)); // x4 holds the data base
		slot++;
	endfunction

	function automatic void begin_prog();
		for (int i = 0; i < `RV_MEM_WORDS; i++) begin
			prog[i] = (i << 16) ^ (i * 32'h9e37) ^ 32'h5a00_00a5;
		end
		pos  = 0;
		slot = 0;
		load_imm(5'd4, 32'h800);
	endfunction

	function automatic void finish_prog();
		logic [31:0] off;
		off = `RV_EXIT_PC - pos * 4;
		emit(enc_j(off[20:0], 5'd0));
	endfunction

	function automatic logic [31:0] alu_ref(logic [2:0] f3, logic alt, logic [31:0] a,
		logic [31:0] b);
		logic [31:0] r;
		case (f3)
			F3_ADD:  r = alt ? a - b : a + b;
			F3_SLL:  r = a << b[4:0];
			F3_SLT:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			F3_SLTU: r = (a < b) ? 32'd1 : 32'd0;
			F3_XOR:  r = a ^ b;
			F3_SR:   r = alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
			F3_OR:   r = a | b;
			default: r = a & b;
		endcase
		return r;
	endfunction

	// ISA-level model that fills the expected store queue and gp
	function automatic void ref_run();
		logic [31:0] x [32];
		logic [31:0] mem [`RV_MEM_WORDS];
		logic [31:0] pc, npc, ins, a, b, wv, addr, old, nv, src;
		logic [31:0] immi, imms, immb, immj;
		logic [31:0] mtvec, mscratch, mepc, mcause;
		logic [2:0]  f3;
		logic [4:0]  rd;
		logic        wr, tk;
		for (int i = 0; i < 32; i++) x[i] = 0;
		for (int i = 0; i < `RV_MEM_WORDS; i++) mem[i] = prog[i];
		pc = 0;
		mtvec = 0;
		mscratch = 0;
		mepc = 0;
		mcause = 0;
		ref_steps = 0;
		exp_addr.delete();
		exp_data.delete();
		while (pc != `RV_EXIT_PC && ref_steps < 5000) begin
			ins  = mem[pc[11:2]];
			f3   = ins[14:12];
			rd   = ins[11:7];
			a    = x[ins[19:15]];
			b    = x[ins[24:20]];
			immi = {{20{ins[31]}}, ins[31:20]};
			imms = {{20{ins[31]}}, ins[31:25], ins[11:7]};
			immb = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
			immj = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
			npc  = pc + 4;
			wr   = 1'b0;
			wv   = 0;
			case (ins[6:0])
				OPC_LOAD: begin
					addr = a + immi;
					wv = mem[addr[11:2]];
					wr = 1'b1;
				end
				OPC_STORE: begin
					addr = a + imms;
					mem[addr[11:2]] = b;
					exp_addr.push_back(addr);
					exp_data.push_back(b);
				end
				OPC_OP: begin
					wv = alu_ref(f3, ins[30], a, b);
					wr = 1'b1;
				end
				OPC_OP_IMM: begin
					wv = alu_ref(f3, ins[30] && f3 == F3_SR, a, immi);
					wr = 1'b1;
				end
				OPC_BRANCH: begin
					case (f3)
						F3_BEQ:  tk = (a == b);
						F3_BNE:  tk = (a != b);
						F3_BLT:  tk = ($signed(a) < $signed(b));
						F3_BGE:  tk = !($signed(a) < $signed(b));
						F3_BLTU: tk = (a < b);
						default: tk = !(a < b);
					endcase
					if (tk) npc = pc + immb;
				end
				OPC_JAL: begin
					wv = pc + 4;
					wr = 1'b1;
					npc = pc + immj;
				end
				OPC_JALR: begin
					wv = pc + 4;
					wr = 1'b1;
					npc = (a + immi) & ~32'd1;
				end
				OPC_LUI: begin
					wv = {ins[31:12], 12'h0};
					wr = 1'b1;
				end
				OPC_AUIPC: begin
					wv = pc + {ins[31:12], 12'h0};
					wr = 1'b1;
				end
				OPC_SYSTEM: begin
					if (f3 == 3'b000) begin // ecall
						mcause = 32'd11;
						npc = mtvec;
					end else begin
						src = f3[2] ? {27'd0, ins[19:15]} : a;
						case (ins[31:20])
							CSR_MTVEC:    old = mtvec;
							CSR_MSCRATCH: old = mscratch;
							CSR_MEPC:     old = mepc;
							CSR_MCAUSE:   old = mcause;
							default:      old = 0;
						endcase
						case (f3[1:0])
							2'b01:   nv = src;
							2'b10:   nv = old | src;
							default: nv = old & ~src;
						endcase
						case (ins[31:20])
							CSR_MTVEC:    mtvec = nv;
							CSR_MSCRATCH: mscratch = nv;
							CSR_MEPC:     mepc = nv;
							CSR_MCAUSE:   mcause = nv;
							default: ;
						endcase
						wv = old;
						wr = 1'b1;
					end
				end
				default: ;
			endcase
			if (wr && rd != 0) x[rd] = wv;
			pc = npc;
			ref_steps++;
		end
		exp_gp = x[3];
	endfunction

	task automatic check(string name, logic [31:0] expected, logic [31:0] actual);
		if (expected !== actual) begin
			$display("Fail %s expected %h actual %h", name, expected, actual);
			$display("** FAIL **");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic run_program(string name);
		test_name = name;
		ref_run();
		@(negedge clk);
		rst_n = 1'b0;
		for (int i = 0; i < `RV_MEM_WORDS; i++) begin
			load_we   = 1'b1;
			load_addr = i * 4;
			load_data = prog[i];
			@(negedge clk);
		end
		load_we = 1'b0;
		repeat (5) @(negedge clk);
		watch_limit = ref_steps * 3 + 50;
		run_cycles  = 0;
		running     = 1'b1;
		rst_n       = 1'b1;
		@(negedge clk);
		while (!exit) @(negedge clk);
		running = 1'b0;
		check({name, " gp"}, exp_gp, gp);
		check({name, " stores left"}, 32'd0, exp_addr.size());
		repeat (20) @(negedge clk); // monitor flags any late store
		check({name, " exit held"}, 32'd1, {31'd0, exit});
		check({name, " gp held"}, exp_gp, gp);
	endtask

	always @(negedge clk) begin
		if (rst_n && store) begin
			if (exp_addr.size() == 0) begin
				$display("store to %h in %s that the model did not expect", store_addr, test_name);
				$display("** FAIL **");
				$fatal(1, "unexpected store");
			end else begin
				check({test_name, " store addr"}, exp_addr.pop_front(), store_addr);
				check({test_name, " store data"}, exp_data.pop_front(), store_data);
			end
		end
	end

	// watchdog
	always @(negedge clk) begin
		if (running) begin
			run_cycles++;
			if (run_cycles > watch_limit) begin
				$display("%s did not reach the exit address in %0d cycles", test_name,
					watch_limit);
				$display("** FAIL **");
				$fatal(1, "timeout");
			end
		end
	end

	initial begin
		logic [2:0]  f3s [10];
		logic        alts [10];
		logic [2:0]  bf3 [6];
		logic [31:0] va, vb, q;
		logic [11:0] imm;
		f3s  = '{F3_ADD, F3_ADD, F3_SLL, F3_SLT, F3_SLTU, F3_XOR, F3_SR, F3_SR, F3_OR, F3_AND};
		alts = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
		bf3  = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
		rst_n     = 1'b0;
		load_we   = 1'b0;
		load_addr = '0;
		load_data = '0;
		running   = 1'b0;
		rng       = 32'h8f0efc4a;

		begin_prog();
		for (int k = 0; k < 20; k++) begin
			load_imm(5'd5, next_rand());
			load_imm(5'd6, next_rand());
			emit(enc_r(alts[k % 10] ? F7_ALT : F7_BASE, 5'd6, 5'd5, f3s[k % 10], 5'd7));
			store_out(5'd7);
			if (k % 10 != 1) begin // no subi
				q = next_rand();
				imm = q[11:0];
				if (f3s[k % 10] == F3_SLL || f3s[k % 10] == F3_SR) begin
					imm = {alts[k % 10] ? F7_ALT : F7_BASE, imm[4:0]};
				end
				emit(enc_i(imm, 5'd5, f3s[k % 10], 5'd8, OPC_OP_IMM));
				store_out(5'd8);
			end
		end
		finish_prog();
		run_program("alu");

		begin_prog();
		for (int k = 0; k < 18; k++) begin
			va = next_rand();
			vb = next_rand();
			if (k % 3 == 1) vb = va;
			if (k % 3 == 2) begin
				va = va | 32'h8000_0000;
				vb = vb >> 1;
			end
			load_imm(5'd5, va);
			load_imm(5'd6, vb);
			emit(enc_b(13'd12, 5'd6, 5'd5, bf3[k / 3]));
			emit(enc_i(12'(2 * k + 2), 5'd0, F3_ADD, 5'd7, OPC_OP_IMM)); // not taken
			emit(enc_j(21'd8, 5'd0));
			emit(enc_i(12'(2 * k + 1), 5'd0, F3_ADD, 5'd7, OPC_OP_IMM)); // taken
			store_out(5'd7);
			emit(enc_r(F7_BASE, 5'd7, 5'd3, F3_ADD, 5'd3)); // checksum in gp
		end
		finish_prog();
		run_program("branch");

		begin_prog();
		emit(enc_j(21'd8, 5'd1));
		emit(enc_i(12'd77, 5'd3, F3_ADD, 5'd3, OPC_OP_IMM)); // skipped
		store_out(5'd1);
		emit(enc_u(20'd0, 5'd10, OPC_AUIPC));
		emit(enc_i(12'd13, 5'd10, F3_JALR, 5'd2, OPC_JALR)); // odd target loses bit 0
		emit(enc_i(12'd55, 5'd3, F3_ADD, 5'd3, OPC_OP_IMM)); // skipped
		store_out(5'd2);
		store_out(5'd10);
		q = next_rand();
		emit(enc_u(q[19:0], 5'd11, OPC_LUI));
		store_out(5'd11);
		q = next_rand();
		emit(enc_u(q[19:0], 5'd12, OPC_AUIPC));
		store_out(5'd12);
		finish_prog();
		run_program("jump");

		begin_prog();
		load_imm(5'd5, next_rand());
		load_imm(5'd6, next_rand());
		emit(enc_s(12'h100, 5'd5, 5'd4));
		emit(enc_s(12'h104, 5'd6, 5'd4));
		emit(enc_i(12'h100, 5'd4, F3_LW, 5'd7, OPC_LOAD));
		emit(enc_i(12'h104, 5'd4, F3_LW, 5'd8, OPC_LOAD));
		store_out(5'd8);
		store_out(5'd7);
		emit(enc_s(12'h100, 5'd6, 5'd4)); // overwrite, same address
		emit(enc_i(12'h100, 5'd4, F3_LW, 5'd9, OPC_LOAD));
		store_out(5'd9);
		finish_prog();
		run_program("memory");

		begin_prog();
		load_imm(5'd5, 32'h400);
		emit(enc_i(CSR_MTVEC, 5'd5, F3_CSRRW, 5'd6, OPC_SYSTEM));
		store_out(5'd6);
		load_imm(5'd7, next_rand());
		emit(enc_i(CSR_MSCRATCH, 5'd7, F3_CSRRW, 5'd8, OPC_SYSTEM));
		store_out(5'd8);
		load_imm(5'd9, next_rand());
		emit(enc_i(CSR_MSCRATCH, 5'd9, F3_CSRRS, 5'd8, OPC_SYSTEM));
		store_out(5'd8);
		load_imm(5'd10, next_rand());
		emit(enc_i(CSR_MSCRATCH, 5'd10, F3_CSRRC, 5'd8, OPC_SYSTEM));
		store_out(5'd8);
		emit(enc_i(CSR_MSCRATCH, 5'd21, F3_CSRRSI, 5'd8, OPC_SYSTEM));
		store_out(5'd8);
		emit(enc_i(CSR_MSCRATCH, 5'd3, F3_CSRRCI, 5'd8, OPC_SYSTEM));
		store_out(5'd8);
		emit(enc_i(CSR_MSCRATCH, 5'd7, F3_CSRRWI, 5'd8, OPC_SYSTEM));
		store_out(5'd8);
		emit(enc_i(CSR_MSCRATCH, 5'd0, F3_CSRRS, 5'd8, OPC_SYSTEM));
		store_out(5'd8);
		emit(INST_ECALL);
		finish_prog(); // only reached if the trap is lost
		pos = 256; // handler at 0x400
		emit(enc_i(CSR_MCAUSE, 5'd0, F3_CSRRS, 5'd8, OPC_SYSTEM));
		store_out(5'd8);
		emit(enc_i(CSR_MTVEC, 5'd0, F3_CSRRS, 5'd8, OPC_SYSTEM));
		store_out(5'd8);
		finish_prog();
		run_program("csr");

		begin_prog();
		emit(enc_i(12'd123, 5'd0, F3_ADD, 5'd0, OPC_OP_IMM));
		emit(enc_u(20'habcde, 5'd0, OPC_LUI));
		emit(enc_r(F7_BASE, 5'd4, 5'd4, F3_ADD, 5'd0));
		store_out(5'd0);
		load_imm(5'd3, 32'h1234);
		store_out(5'd3);
		finish_prog();
		run_program("x0");

		$display("** PASS **");
		$finish;
	end

endmodule

// File: src.f
+incdir+include
logic/rv_isa_pkg.sv
logic/rv_ctrl_pkg.sv
logic/rv_decoder.sv
logic/rv_exec_unit.sv
logic/rv_csr_file.sv
logic/rv_core.sv
logic/rv_memory.sv
logic/rv_system.sv
tests/tb_clock.sv
tests/tb_top.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f src.f --top-module tb_top -o tb_sim
if [ $? -ne 0 ]; then
	echo "verilator compile failed"
	exit 1
fi

out=$(./obj_dir/tb_sim 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q '\*\* PASS \*\*'; then
	exit 0
fi
exit 1
